// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_fetch_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/rv_fetch_tb.sv
module rv_fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD     = 50;
    localparam int DRIVE_DLY       = 5;
    localparam int RESET_CYCLES    = 5;
    localparam int CYCLES_PER_INST = 20;
    localparam int N_CASES         = 6;

    typedef struct packed
    {
        rv_fetch_pkg::addr_t boot_pc;
        int                  stall_pct;     // chance per cycle that a stall burst starts
        int                  comp_pct;      // share of compressed instructions
        int                  count;
    } case_t;

    localparam case_t CASES [N_CASES] = '{
        '{32'h0000_0000,  0,   0, 24},     // all 32-bit, aligned start
        '{32'h0000_0040,  0, 100, 24},     // all compressed
        '{32'h0000_0100,  0,  50, 40},     // mixed, straddles word boundaries
        '{32'h0000_0082,  0,  50, 30},     // starts on the high parcel
        '{32'h0000_01f6, 40,  40, 40},     // random and long stalls
        '{32'h0000_03ba, 25,  30, 30}      // wraps past the top of memory
    };

    logic                clk;
    logic                reset_n;
    rv_fetch_pkg::addr_t boot_pc;
    logic                stall;
    logic                imem_req;
    rv_fetch_pkg::addr_t imem_addr;
    rv_fetch_pkg::word_t imem_rdata;
    logic                inst_valid;
    rv_fetch_pkg::inst_t inst;
    rv_fetch_pkg::addr_t inst_pc;
    logic                inst_compressed;

    rv_fetch_pkg::word_t image [256];       // program image, also read by the reference
    rv_fetch_pkg::word_t rng_state;
    rv_fetch_pkg::inst_t exp_inst [$];
    rv_fetch_pkg::addr_t exp_pc [$];
    logic                exp_comp [$];
    int                  cycle_count = 0;
    int                  cycle_limit = 0;

    rv_fetch_top DUT
    (
        .i_clk             (clk),
        .i_reset_n         (reset_n),
        .i_boot_pc         (boot_pc),
        .i_stall           (stall),
        .o_imem_req        (imem_req),
        .o_imem_addr       (imem_addr),
        .i_imem_rdata      (imem_rdata),
        .o_inst_valid      (inst_valid),
        .o_inst            (inst),
        .o_inst_pc         (inst_pc),
        .o_inst_compressed (inst_compressed)
    );

    rv_imem_model u_imem
    (
        .i_clk   (clk),
        .i_req   (imem_req),
        .i_addr  (imem_addr),
        .o_rdata (imem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    function automatic rv_fetch_pkg::word_t next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int cycle_budget();
        int sum;
        sum = 0;
        for (int c = 0; c < N_CASES; c++)
            sum += CYCLES_PER_INST * CASES[c].count;
        return sum;
    endfunction

    // parcel index is a halfword address, so it wraps with the 256-word memory
    function automatic rv_fetch_pkg::halfword_t read_parcel(input logic [8:0] p);
        return p[0] ? image[p[8:1]][31:16] : image[p[8:1]][15:0];
    endfunction

    task automatic write_parcel(input logic [8:0] p, input rv_fetch_pkg::halfword_t v);
        if (p[0])
            image[p[8:1]][31:16] = v;
        else
            image[p[8:1]][15:0] = v;
    endtask

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic build_program(input case_t tc);
        logic [7:0]              w;
        logic [8:0]              p;
        rv_fetch_pkg::word_t     r;
        rv_fetch_pkg::halfword_t half;
        w = '0;
        repeat (256)
        begin
            image[w] = next_random();
            w++;
        end
        p = tc.boot_pc[9:1];
        repeat (tc.count)
        begin
            r = next_random();
            if (int'(r[31:16]) % 100 < tc.comp_pct)
            begin
                half = r[27:12];
                if (half[1:0] == 2'b11)
                    half[1:0] = 2'b01;      // keep it compressed
                write_parcel(p, half);
                p = p + 9'd1;
            end
            else
            begin
                write_parcel(p, {r[27:14], 2'b11});
                r = next_random();
                write_parcel(p + 9'd1, r[31:16]);
                p = p + 9'd2;
            end
        end
        w = '0;
        repeat (256)
        begin
            u_imem.mem[w] = image[w];
            w++;
        end
    endtask

    // walk the image from the boot pc, sizing each instruction by its low two bits
    task automatic build_expected(input case_t tc);
        rv_fetch_pkg::addr_t     pc;
        rv_fetch_pkg::halfword_t lo;
        exp_inst.delete();
        exp_pc.delete();
        exp_comp.delete();
        pc = tc.boot_pc;
        repeat (tc.count)
        begin
            lo = read_parcel(pc[9:1]);
            exp_pc.push_back(pc);
            if (lo[1:0] != 2'b11)
            begin
                exp_inst.push_back({16'h0000, lo});
                exp_comp.push_back(1'b1);
                pc = pc + 32'd2;
            end
            else
            begin
                exp_inst.push_back({read_parcel(pc[9:1] + 9'd1), lo});
                exp_comp.push_back(1'b0);
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic apply_reset(input rv_fetch_pkg::addr_t pc);
        reset_n = 1'b0;
        boot_pc = pc;
        stall   = 1'b0;
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            check_word("o_imem_req", {31'b0, imem_req}, 32'h0);
            check_word("o_inst_valid", {31'b0, inst_valid}, 32'h0);
        end
        reset_n = 1'b1;
    endtask

    task automatic run_case(input case_t tc);
        int                  got;
        int                  stall_left;
        rv_fetch_pkg::word_t r;
        rv_fetch_pkg::addr_t exp_addr;
        build_program(tc);
        build_expected(tc);
        apply_reset(tc.boot_pc);
        got        = 0;
        stall_left = 0;
        exp_addr   = tc.boot_pc & ~32'h3;   // word that holds the boot pc
        while (got < tc.count)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            // stall still holds its value from the cycle that just ended
            assert (!(stall && inst_valid))
            else
            begin
                $display("o_inst_valid was high in the cycle after a stalled cycle");
                abort_run();
            end
            if (imem_req)
            begin
                check_word("o_imem_addr", imem_addr, exp_addr);
                exp_addr = exp_addr + 32'd4;
            end
            if (inst_valid)
            begin
                check_word("o_inst", inst, exp_inst[got]);
                check_word("o_inst_pc", inst_pc, exp_pc[got]);
                check_word("o_inst_compressed", {31'b0, inst_compressed},
                           {31'b0, exp_comp[got]});
                got++;
            end
            if (stall_left > 0)
            begin
                stall_left--;
                stall = 1'b1;
            end
            else
            begin
                r = next_random();
                if (int'(r[31:16]) % 100 < tc.stall_pct)
                begin
                    stall_left = (r[11:8] == 4'h0) ? 15 : int'(r[9:8]);  // rare long burst
                    stall      = 1'b1;
                end
                else
                    stall = 1'b0;
            end
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: tests not finished after %0d cycles", cycle_count);
            abort_run();
        end
    end

    initial
    begin
        reset_n     = 1'b0;
        boot_pc     = '0;
        stall       = 1'b0;
        rng_state   = 32'h5d51;
        cycle_limit = cycle_budget();
        for (int c = 0; c < N_CASES; c++)
        begin
            $display("case %0d: boot pc %h, %0d instructions", c, CASES[c].boot_pc,
                     CASES[c].count);
            run_case(CASES[c]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: bench/rv_imem_model.sv
module rv_imem_model
#(
    parameter int WORDS = 256
)
(
    input  logic                i_clk,
    input  logic                i_req,
    input  rv_fetch_pkg::addr_t i_addr,
    output rv_fetch_pkg::word_t o_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDX_W = $clog2(WORDS);

    rv_fetch_pkg::word_t mem [WORDS];       // loaded by the testbench

    // fixed one-cycle read latency, addresses wrap at the top
    always_ff @(posedge i_clk)
    begin
        if (i_req)
            o_rdata <= mem[i_addr[IDX_W+1:2]];
    end

endmodule

// File: logic/rv_buf_if.sv
interface buf_push_if;
    rv_fetch_pkg::halfword_t data_lo;
    rv_fetch_pkg::halfword_t data_hi;
    logic                    push_single;   // stores data_hi only
    logic                    push_double;   // stores data_lo, then data_hi
    logic                    full;

    modport producer
    (
        output data_lo,
        output data_hi,
        output push_single,
        output push_double,
        input  full
    );

    modport buffer
    (
        input  data_lo,
        input  data_hi,
        input  push_single,
        input  push_double,
        output full
    );
endinterface

interface buf_pop_if;
    rv_fetch_pkg::halfword_t data_lo;       // head parcel
    rv_fetch_pkg::halfword_t data_hi;
    logic                    pop_single;
    logic                    pop_double;
    logic                    empty;         // head instruction not complete
    logic                    compressed;

    modport buffer
    (
        output data_lo,
        output data_hi,
        input  pop_single,
        input  pop_double,
        output empty,
        output compressed
    );

    modport consumer
    (
        input  data_lo,
        input  data_hi,
        output pop_single,
        output pop_double,
        input  empty,
        input  compressed
    );
endinterface

// File: logic/rv_fetch_buf.sv
module rv_fetch_buf
#(
    parameter int DEPTH_BITS = rv_fetch_pkg::DEFAULT_DEPTH_BITS
)
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    buf_push_if.buffer push,
    buf_pop_if.buffer  pop
);

    localparam int DEPTH      = 2 ** DEPTH_BITS;
    localparam int FULL_LEVEL = DEPTH - 2;  // leaves room for one in-flight word

    logic [DEPTH_BITS:0]     head;          // parcel count
    logic [DEPTH_BITS:0]     head_next;
    logic [DEPTH_BITS:0]     delta_pop;
    logic [DEPTH_BITS:0]     delta_push;
    logic                    any_pop;
    logic                    head_comp;
    rv_fetch_pkg::halfword_t data [DEPTH];

    assign any_pop = pop.pop_single | pop.pop_double;

    // -1 or -2 in two's complement
    assign delta_pop  = {{DEPTH_BITS{any_pop}}, pop.pop_single & ~pop.pop_double};
    assign delta_push = {{(DEPTH_BITS-1){1'b0}}, push.push_double, push.push_single};
    assign head_next  = head + delta_pop + delta_push;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            head <= '0;
        else
            head <= head_next;
    end

    // entry 0 is the head; a pop shifts everything down, new parcels land on top
    for (genvar i = 0; i < DEPTH; i++)
    begin : g_entry
        logic                    wr_hi;
        logic                    wr_lo;
        rv_fetch_pkg::halfword_t up1;
        rv_fetch_pkg::halfword_t up2;
        rv_fetch_pkg::halfword_t next;

        assign wr_hi = (push.push_single | push.push_double) & (int'(head_next) == i + 1);
        assign wr_lo = push.push_double & (int'(head_next) == i + 2);

        if (i + 2 < DEPTH)
        begin : g_mid
            assign up1 = data[i + 1];
            assign up2 = data[i + 2];
        end
        else if (i + 1 < DEPTH)
        begin : g_below_top
            assign up1 = data[i + 1];
            assign up2 = '0;
        end
        else
        begin : g_top
            assign up1 = '0;
            assign up2 = '0;
        end

        assign next = wr_hi          ? push.data_hi :
                      wr_lo          ? push.data_lo :
                      pop.pop_single ? up1 :
                      up2;

        always_ff @(posedge i_clk)
        begin
            if (wr_hi | wr_lo | any_pop)
                data[i] <= next;
        end
    end

    assign head_comp = (data[0][1:0] != 2'b11);

    assign pop.data_lo    = data[0];
    assign pop.data_hi    = data[1];
    assign pop.compressed = head_comp;
    // head == 0 first, so stale storage never reaches empty
    assign pop.empty      = (head == '0) | (~head_comp & (int'(head) < 2));
    assign push.full      = (int'(head) >= FULL_LEVEL);

    a_no_push_when_full : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        push.push_double |-> !push.full
    );

    a_no_pop_when_empty : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        any_pop |-> !pop.empty
    );

    a_one_pop_strobe : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        !(pop.pop_single & pop.pop_double)
    );

endmodule

// File: logic/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // one RVC parcel, a memory word is two of them
    localparam int HALF_W = 16;
    localparam int WORD_W = 2 * HALF_W;
    localparam int ADDR_W = 32;

    // log2 of the buffer depth in parcels
    localparam int DEFAULT_DEPTH_BITS = 3;

    typedef logic [HALF_W-1:0] halfword_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // compressed instructions sit in the low half, upper half zero
    typedef logic [WORD_W-1:0] inst_t;

endpackage

// File: logic/rv_fetch_top.sv
module rv_fetch_top
#(
    parameter int DEPTH_BITS = rv_fetch_pkg::DEFAULT_DEPTH_BITS
)
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  rv_fetch_pkg::addr_t i_boot_pc,
    input  logic                i_stall,
    output logic                o_imem_req,
    output rv_fetch_pkg::addr_t o_imem_addr,
    input  rv_fetch_pkg::word_t i_imem_rdata,
    output logic                o_inst_valid,
    output rv_fetch_pkg::inst_t o_inst,
    output rv_fetch_pkg::addr_t o_inst_pc,
    output logic                o_inst_compressed
);

    buf_push_if push_bus ();
    buf_pop_if  pop_bus ();

    rv_fetch_unit u_fetch
    (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_boot_pc    (i_boot_pc),
        .o_imem_req   (o_imem_req),
        .o_imem_addr  (o_imem_addr),
        .i_imem_rdata (i_imem_rdata),
        .push         (push_bus.producer)
    );

    rv_fetch_buf
    #(
        .DEPTH_BITS (DEPTH_BITS)
    )
    u_buf
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .push      (push_bus.buffer),
        .pop       (pop_bus.buffer)
    );

    rv_inst_align u_align
    (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_boot_pc         (i_boot_pc),
        .i_stall           (i_stall),
        .pop               (pop_bus.consumer),
        .o_inst_valid      (o_inst_valid),
        .o_inst            (o_inst),
        .o_inst_pc         (o_inst_pc),
        .o_inst_compressed (o_inst_compressed)
    );

endmodule

// File: logic/rv_fetch_unit.sv
module rv_fetch_unit
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  rv_fetch_pkg::addr_t i_boot_pc,
    output logic                o_imem_req,
    output rv_fetch_pkg::addr_t o_imem_addr,
    input  rv_fetch_pkg::word_t i_imem_rdata,
    buf_push_if.producer        push
);

    rv_fetch_pkg::addr_t fetch_addr;
    logic                running;       // low until the first cycle out of reset
    logic                in_flight;     // response arrives this cycle
    logic                skip_lo;       // boot pc points at the high parcel
    logic                req;

    // one request at a time, and only with room for a whole word
    assign req = running & ~in_flight & ~push.full;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            running    <= 1'b0;
            in_flight  <= 1'b0;
            skip_lo    <= i_boot_pc[1];
            fetch_addr <= i_boot_pc & ~rv_fetch_pkg::addr_t'(3);
        end
        else
        begin
            running   <= 1'b1;
            in_flight <= req;
            if (in_flight)
                skip_lo <= 1'b0;    // only the first word can be split
            if (req)
                fetch_addr <= fetch_addr + rv_fetch_pkg::addr_t'(4);
        end
    end

    assign o_imem_req  = req;
    assign o_imem_addr = fetch_addr;

    // read data is valid exactly one cycle after the request
    assign push.data_lo     = i_imem_rdata[rv_fetch_pkg::HALF_W-1:0];
    assign push.data_hi     = i_imem_rdata[rv_fetch_pkg::WORD_W-1:rv_fetch_pkg::HALF_W];
    assign push.push_single = in_flight & skip_lo;
    assign push.push_double = in_flight & ~skip_lo;

    a_push_has_room : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (push.push_single | push.push_double) |-> !push.full
    );

endmodule

// File: logic/rv_inst_align.sv
module rv_inst_align
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  rv_fetch_pkg::addr_t i_boot_pc,
    input  logic                i_stall,
    buf_pop_if.consumer         pop,
    output logic                o_inst_valid,
    output rv_fetch_pkg::inst_t o_inst,
    output rv_fetch_pkg::addr_t o_inst_pc,
    output logic                o_inst_compressed
);

    logic                take;
    rv_fetch_pkg::addr_t next_pc;       // pc of the instruction at the buffer head
    rv_fetch_pkg::inst_t inst_d;

    assign take = ~pop.empty & ~i_stall;

    assign pop.pop_single = take & pop.compressed;
    assign pop.pop_double = take & ~pop.compressed;

    assign inst_d = pop.compressed ? {{rv_fetch_pkg::HALF_W{1'b0}}, pop.data_lo} :
                                     {pop.data_hi, pop.data_lo};

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_inst_valid <= 1'b0;
            next_pc      <= i_boot_pc;
        end
        else
        begin
            o_inst_valid <= take;   // one cycle per pop
            if (take)
                next_pc <= next_pc + (pop.compressed ? rv_fetch_pkg::addr_t'(2) :
                                                       rv_fetch_pkg::addr_t'(4));
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (take)
        begin
            o_inst            <= inst_d;
            o_inst_pc         <= next_pc;
            o_inst_compressed <= pop.compressed;
        end
    end

    a_pc_halfword_aligned : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_inst_valid |-> (o_inst_pc[0] == 1'b0)
    );

endmodule

// File: sim.f
logic/rv_fetch_pkg.sv
logic/rv_buf_if.sv
logic/rv_fetch_unit.sv
logic/rv_fetch_buf.sv
logic/rv_inst_align.sv
logic/rv_fetch_top.sv
bench/rv_imem_model.sv
bench/rv_fetch_tb.sv
